// File: design/stack_cpu_pkg.sv
// Stack CPU shared definitions
// Word and address types, opcode and ALU function codes,
// run states and instruction field positions
package stack_cpu_pkg;

   //////////////////////////////////////////////////
   // Widths and types
   //////////////////////////////////////////////////
   localparam int WORD_WIDTH = 18;   // Data word
   localparam int ADDR_WIDTH = 12;   // Memory and PC address
   localparam int FRAC_BITS  = 8;    // 10.8 fixed point
   localparam int NUM_PORTS  = 4;    // In and out ports each

   typedef logic [WORD_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [1:0]            port_idx_t;

   //////////////////////////////////////////////////
   // Instruction fields
   //////////////////////////////////////////////////
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 12;
   localparam int IMM_MSB  = 11;     // Immediate/address is 11:0
   localparam int FUNC_MSB = 4;      // ALU function is 4:0
   localparam int PPPC_BIT = 0;      // 0 pushpc, 1 poppc

   // Opcodes, codes 10 to 12 unused (run as NOP)
   typedef enum logic [3:0] {
      OPC_HALT  = 4'b0000,
      OPC_PUSHI = 4'b0001,
      OPC_PUSH  = 4'b0010,
      OPC_POP   = 4'b0011,
      OPC_JMP   = 4'b0100,
      OPC_JZ    = 4'b0101,
      OPC_JNZ   = 4'b0110,
      OPC_LD    = 4'b0111,
      OPC_ST    = 4'b1000,
      OPC_PPPC  = 4'b1001,
      OPC_IN    = 4'b1101,
      OPC_OUT   = 4'b1110,
      OPC_OP    = 4'b1111
   } opcode_e;

   // ALU functions, bit 4 clear means binary (pops one)
   typedef enum logic [4:0] {
      ALU_ADD  = 5'b00000,
      ALU_SUB  = 5'b00001,
      ALU_MUL  = 5'b00010,
      ALU_SHL  = 5'b00011,
      ALU_SHR  = 5'b00100,
      ALU_BAND = 5'b00101,
      ALU_BOR  = 5'b00110,
      ALU_BXOR = 5'b00111,
      ALU_AND  = 5'b01000,
      ALU_OR   = 5'b01001,
      ALU_EQ   = 5'b01010,
      ALU_NE   = 5'b01011,
      ALU_GE   = 5'b01100,
      ALU_LE   = 5'b01101,
      ALU_GT   = 5'b01110,
      ALU_LT   = 5'b01111,
      ALU_NEG  = 5'b10000,
      ALU_BNOT = 5'b10001,
      ALU_NOT  = 5'b10010,
      ALU_A    = 5'b10011,   // dup
      ALU_B    = 5'b10111,   // drop
      ALU_AA   = 5'b11011,   // dropnext
      ALU_BA   = 5'b11111    // over
   } alu_func_e;

   typedef enum logic [1:0] {
      IDLE_A = 2'b00,
      IDLE_B = 2'b01,       // First fetch
      EXEC   = 2'b10
   } run_state_e;

endpackage

// File: design/stack_ctrl_if.sv
// Decoded control strobes, decoder to stack and result datapath
// All levels are combinational and valid in EXEC only
`timescale 1ns/1ps

interface stack_ctrl_if;

   logic push, pop, pop2, thru, load_top;                       // Stack
   logic dbus_imm, dbus_top, dbus_alu, dbus_ram, dbus_port, dbus_pc; // Data bus source
   logic abus_imm, abus_top, abus_next;                         // Address source
   logic ram_write, port_write;
   logic pc_inc, jump, pop_pc;                                  // PC select

   modport decode (
      output push, pop, pop2, thru, load_top,
      output dbus_imm, dbus_top, dbus_alu, dbus_ram, dbus_port, dbus_pc,
      output abus_imm, abus_top, abus_next,
      output ram_write, port_write,
      output pc_inc, jump, pop_pc
   );

   modport stack (input push, pop, pop2, thru, load_top);

   modport result (
      input dbus_imm, dbus_top, dbus_alu, dbus_ram, dbus_port, dbus_pc,
      input abus_imm, abus_top, abus_next,
      input port_write,
      input pc_inc, jump, pop_pc
   );

endinterface

// File: design/instr_decoder.sv
// Instruction decoder
// Run-state sequencer plus per-opcode strobe decode in EXEC
`timescale 1ns/1ps

module instr_decoder (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     run,
   input  stack_cpu_pkg::word_t     instr,
   input  stack_cpu_pkg::word_t     top,
   output stack_cpu_pkg::run_state_e state,
   stack_ctrl_if.decode             ctrl
);
   import stack_cpu_pkg::*;

   opcode_e   opc;
   alu_func_e func;
   logic      halt;

   assign opc  = opcode_e'(instr[OPC_MSB:OPC_LSB]);
   assign func = alu_func_e'(instr[FUNC_MSB:0]);

   //////////////////////////////////////////////////
   // Run state
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         state <= IDLE_A;
      else
         case (state)
            IDLE_A:  if (run) state <= IDLE_B;
            IDLE_B:  state <= EXEC;             // Fetch done
            EXEC:    if (halt) state <= IDLE_A;
            default: state <= IDLE_A;
         endcase
   end

   //////////////////////////////////////////////////
   // Strobe decode
   //////////////////////////////////////////////////
   always_comb
   begin
      halt            = 1'b0;
      ctrl.push       = 1'b0;
      ctrl.pop        = 1'b0;
      ctrl.pop2       = 1'b0;
      ctrl.thru       = 1'b0;
      ctrl.load_top   = 1'b0;
      ctrl.dbus_imm   = 1'b0;
      ctrl.dbus_top   = 1'b0;
      ctrl.dbus_alu   = 1'b0;
      ctrl.dbus_ram   = 1'b0;
      ctrl.dbus_port  = 1'b0;
      ctrl.dbus_pc    = 1'b0;
      ctrl.abus_imm   = 1'b0;
      ctrl.abus_top   = 1'b0;
      ctrl.abus_next  = 1'b0;
      ctrl.ram_write  = 1'b0;
      ctrl.port_write = 1'b0;
      ctrl.pc_inc     = 1'b0;
      ctrl.jump       = 1'b0;
      ctrl.pop_pc     = 1'b0;

      if (state == EXEC)
         case (opc)
            OPC_HALT:  halt = 1'b1;             // No increment, back to idle
            OPC_PUSHI:
            begin
               ctrl.dbus_imm = 1'b1;
               ctrl.load_top = 1'b1;
               ctrl.push     = 1'b1;
               ctrl.pc_inc   = 1'b1;
            end
            OPC_PUSH:
            begin
               ctrl.abus_imm = 1'b1;
               ctrl.push     = 1'b1;
               ctrl.thru     = 1'b1;            // RAM data lands next cycle
               ctrl.pc_inc   = 1'b1;
            end
            OPC_POP:
            begin
               ctrl.abus_imm  = 1'b1;
               ctrl.dbus_top  = 1'b1;
               ctrl.ram_write = 1'b1;
               ctrl.pop       = 1'b1;
               ctrl.pc_inc    = 1'b1;
            end
            OPC_JMP:   ctrl.jump = 1'b1;
            OPC_JZ, OPC_JNZ:
            begin
               // Taken when top test matches opcode
               if ((top == '0) == (opc == OPC_JZ))
                  ctrl.jump = 1'b1;
               else
                  ctrl.pc_inc = 1'b1;
               ctrl.pop = 1'b1;                 // Always drops the flag
            end
            OPC_LD:
            begin
               ctrl.abus_top = 1'b1;
               ctrl.thru     = 1'b1;            // Replaces top with mem
               ctrl.pc_inc   = 1'b1;
            end
            OPC_ST:
            begin
               ctrl.abus_next = 1'b1;           // next = address
               ctrl.dbus_top  = 1'b1;           // top = value
               ctrl.ram_write = 1'b1;
               ctrl.pop2      = 1'b1;
               ctrl.pc_inc    = 1'b1;
            end
            OPC_PPPC:
               if (!instr[PPPC_BIT])
               begin
                  ctrl.dbus_pc  = 1'b1;         // Push return address
                  ctrl.load_top = 1'b1;
                  ctrl.push     = 1'b1;
                  ctrl.pc_inc   = 1'b1;
               end
               else
               begin
                  ctrl.pop_pc = 1'b1;
                  ctrl.pop    = 1'b1;
               end
            OPC_IN:
            begin
               ctrl.dbus_port = 1'b1;
               ctrl.load_top  = 1'b1;
               ctrl.push      = 1'b1;
               ctrl.pc_inc    = 1'b1;
            end
            OPC_OUT:
            begin
               ctrl.dbus_top   = 1'b1;
               ctrl.port_write = 1'b1;
               ctrl.pop        = 1'b1;
               ctrl.pc_inc     = 1'b1;
            end
            OPC_OP:
            begin
               ctrl.dbus_alu = 1'b1;
               ctrl.load_top = 1'b1;
               ctrl.pc_inc   = 1'b1;
               // Binary ops and drop/dropnext shrink, dup/over grow
               ctrl.pop  = !func[FUNC_MSB] || func == ALU_B || func == ALU_AA;
               ctrl.push = func == ALU_A || func == ALU_BA;
            end
            default:   ctrl.pc_inc = 1'b1;      // Unused codes as NOP
         endcase
   end

endmodule

// File: design/operand_stack.sv
// Operand stack
// Register-file stack growing downward, top/next read ports,
// with a through path that puts memory read data on top
`timescale 1ns/1ps

module operand_stack #(
   parameter int STACK_DEPTH = 8
) (
   input  logic                 clk,
   input  logic                 reset,
   stack_ctrl_if.stack          ctrl,
   input  stack_cpu_pkg::word_t d,          // Data bus
   input  stack_cpu_pkg::word_t mem_data,   // RAM read data
   output stack_cpu_pkg::word_t top,
   output stack_cpu_pkg::word_t next
);
   import stack_cpu_pkg::*;

   localparam int PTR_W = $clog2(STACK_DEPTH);

   word_t            mem [STACK_DEPTH];
   logic [PTR_W-1:0] ptr;          // Current top entry
   logic [PTR_W-1:0] ptr_next;
   logic [PTR_W-1:0] nxt_next;     // Entry under new top
   logic [PTR_W-1:0] top_addr;
   logic [PTR_W-1:0] next_addr;
   logic             thru_q;       // RAM data arrives this cycle
   logic             thru_write;
   word_t            top_wdata;

   //////////////////////////////////////////////////
   // Pointer
   //////////////////////////////////////////////////
   always_comb
   begin
      if (ctrl.push)
         ptr_next = ptr - 1'b1;
      else if (ctrl.pop)
         ptr_next = ptr + 1'b1;
      else if (ctrl.pop2)
         ptr_next = ptr + PTR_W'(2);
      else
         ptr_next = ptr;
   end

   assign nxt_next = ptr_next + 1'b1;

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         ptr    <= '0;
         thru_q <= 1'b0;
      end
      else
      begin
         ptr    <= ptr_next;
         thru_q <= ctrl.thru;      // Matches RAM read latency
      end
   end

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////
   // Delayed through data is committed unless the stack moves
   assign thru_write = thru_q && !(ctrl.push || ctrl.pop || ctrl.pop2);
   assign top_wdata  = ctrl.load_top ? d : mem_data;

   always_ff @(posedge clk)
   begin
      if (ctrl.load_top || thru_write)
         mem[ptr_next] <= top_wdata;
      if (ctrl.push && thru_q)
         mem[nxt_next] <= mem_data;  // Pending through value sinks one
      top_addr  <= ptr_next;
      next_addr <= nxt_next;
   end

   assign top  = thru_q ? mem_data : mem[top_addr];
   assign next = mem[next_addr];

endmodule

// File: design/stack_alu.sv
// Stack ALU
// Computes b op a over 23 functions, comparisons in offset binary,
// multiply in signed 10.8 fixed point
`timescale 1ns/1ps

module stack_alu (
   input  stack_cpu_pkg::word_t     a,       // Top
   input  stack_cpu_pkg::word_t     b,       // Next
   input  stack_cpu_pkg::alu_func_e func,
   output stack_cpu_pkg::word_t     result
);
   import stack_cpu_pkg::*;

   localparam word_t SIGN_OFS = {1'b1, {(WORD_WIDTH-1){1'b0}}};  // 0x20000

   word_t                         a_ofs;
   word_t                         b_ofs;
   logic signed [2*WORD_WIDTH-1:0] prod;
   word_t                         mul_out;

   // Offset binary so signed order becomes unsigned order
   assign a_ofs = a + SIGN_OFS;
   assign b_ofs = b + SIGN_OFS;

   assign prod    = $signed(a) * $signed(b);
   assign mul_out = {prod[2*WORD_WIDTH-1], prod[WORD_WIDTH+FRAC_BITS-2:FRAC_BITS]};

   always_comb
   begin
      case (func)
         ALU_ADD:  result = b + a;
         ALU_SUB:  result = b - a;
         ALU_MUL:  result = mul_out;
         ALU_SHL:  result = b << a;
         ALU_SHR:  result = b >> a;
         ALU_BAND: result = b & a;
         ALU_BOR:  result = b | a;
         ALU_BXOR: result = b ^ a;
         ALU_AND:  result = word_t'((b != '0) && (a != '0));   // 0 or 1
         ALU_OR:   result = word_t'((b != '0) || (a != '0));
         ALU_EQ:   result = word_t'(b == a);
         ALU_NE:   result = word_t'(b != a);
         ALU_GE:   result = word_t'(b_ofs >= a_ofs);
         ALU_LE:   result = word_t'(b_ofs <= a_ofs);
         ALU_GT:   result = word_t'(b_ofs > a_ofs);
         ALU_LT:   result = word_t'(b_ofs < a_ofs);
         ALU_NEG:  result = -a;
         ALU_BNOT: result = ~a;
         ALU_NOT:  result = word_t'(a == '0);
         ALU_A,
         ALU_AA:   result = a;       // dup, dropnext
         ALU_B,
         ALU_BA:   result = b;       // drop, over
         default:  result = '0;
      endcase
   end

endmodule

// File: design/program_ram.sv
// Program and data memory
// One read/write port for data, one read-only port for fetch,
// both with a registered read
`timescale 1ns/1ps

module program_ram #(
   parameter int RAM_WORDS = 4096
) (
   input  logic                 clk,
   input  logic                 write,
   input  stack_cpu_pkg::addr_t addr,
   input  stack_cpu_pkg::word_t d,
   output stack_cpu_pkg::word_t q,
   input  stack_cpu_pkg::addr_t fetch_addr,
   output stack_cpu_pkg::word_t instr
);
   import stack_cpu_pkg::*;

   word_t mem [RAM_WORDS];

   // Data port, old data on a write cycle
   always_ff @(posedge clk)
   begin
      if (write)
         mem[addr] <= d;
      q <= mem[addr];
   end

   // Fetch port
   always_ff @(posedge clk)
   begin
      instr <= mem[fetch_addr];
   end

endmodule

// File: design/writeback_unit.sv
// Bus and writeback unit
// Data and address bus select, program counter and
// the output port registers
`timescale 1ns/1ps

module writeback_unit (
   input  logic                      clk,
   input  logic                      reset,
   input  stack_cpu_pkg::run_state_e state,
   stack_ctrl_if.result              ctrl,
   input  stack_cpu_pkg::word_t      instr,
   input  stack_cpu_pkg::word_t      top,
   input  stack_cpu_pkg::word_t      next,
   input  stack_cpu_pkg::word_t      alu_result,
   input  stack_cpu_pkg::word_t      ram_q,
   input  stack_cpu_pkg::word_t      in0,
   input  stack_cpu_pkg::word_t      in1,
   input  stack_cpu_pkg::word_t      in2,
   input  stack_cpu_pkg::word_t      in3,
   output stack_cpu_pkg::word_t      dbus,
   output stack_cpu_pkg::addr_t      abus,
   output stack_cpu_pkg::addr_t      pc_next,
   output stack_cpu_pkg::word_t      out0,
   output stack_cpu_pkg::word_t      out1,
   output stack_cpu_pkg::word_t      out2,
   output stack_cpu_pkg::word_t      out3
);
   import stack_cpu_pkg::*;

   addr_t     imm;
   word_t     imm_ext;
   port_idx_t port_idx;
   word_t     in_port  [NUM_PORTS];
   word_t     out_port [NUM_PORTS];
   addr_t     pc;

   assign imm      = instr[IMM_MSB:0];
   assign imm_ext  = {{(WORD_WIDTH-ADDR_WIDTH){imm[IMM_MSB]}}, imm};  // Sign extend
   assign port_idx = instr[$bits(port_idx_t)-1:0];

   assign in_port[0] = in0;
   assign in_port[1] = in1;
   assign in_port[2] = in2;
   assign in_port[3] = in3;

   //////////////////////////////////////////////////
   // Bus select
   //////////////////////////////////////////////////
   always_comb
   begin
      if (ctrl.dbus_imm)       dbus = imm_ext;
      else if (ctrl.dbus_top)  dbus = top;
      else if (ctrl.dbus_alu)  dbus = alu_result;
      else if (ctrl.dbus_ram)  dbus = ram_q;
      else if (ctrl.dbus_port) dbus = in_port[port_idx];
      else if (ctrl.dbus_pc)   dbus = word_t'(pc_next);   // Return address
      else                     dbus = '0;
   end

   always_comb
   begin
      if (ctrl.abus_imm)       abus = imm;
      else if (ctrl.abus_top)  abus = top[ADDR_WIDTH-1:0];
      else if (ctrl.abus_next) abus = next[ADDR_WIDTH-1:0];
      else                     abus = '0;
   end

   //////////////////////////////////////////////////
   // Program counter, pc_next is also the fetch address
   //////////////////////////////////////////////////
   always_comb
   begin
      if (state == IDLE_B)     pc_next = pc;
      else if (ctrl.pc_inc)    pc_next = pc + 1'b1;
      else if (ctrl.jump)      pc_next = imm;
      else if (ctrl.pop_pc)    pc_next = top[ADDR_WIDTH-1:0];
      else                     pc_next = pc;     // Halt holds
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         pc <= '0;
      else if (ctrl.pc_inc || ctrl.jump || ctrl.pop_pc)
         pc <= pc_next;
   end

   // Output ports
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         for (int i = 0; i < NUM_PORTS; i++)
            out_port[i] <= '0;
      else if (ctrl.port_write)
         out_port[port_idx] <= dbus;
   end

   assign out0 = out_port[0];
   assign out1 = out_port[1];
   assign out2 = out_port[2];
   assign out3 = out_port[3];

endmodule

// File: design/stack_cpu.sv
// 18-bit stack processor core
// Decoder, operand stack, ALU, shared program/data RAM and
// writeback, with a program-load port used while idle
`timescale 1ns/1ps

module stack_cpu #(
   parameter int STACK_DEPTH = 8,
   parameter int RAM_WORDS   = 4096
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   input  logic                 prog_write,
   input  stack_cpu_pkg::addr_t prog_addr,
   input  stack_cpu_pkg::word_t prog_data,
   input  stack_cpu_pkg::word_t in0,
   input  stack_cpu_pkg::word_t in1,
   input  stack_cpu_pkg::word_t in2,
   input  stack_cpu_pkg::word_t in3,
   output stack_cpu_pkg::word_t out0,
   output stack_cpu_pkg::word_t out1,
   output stack_cpu_pkg::word_t out2,
   output stack_cpu_pkg::word_t out3,
   output logic                 busy
);
   import stack_cpu_pkg::*;

   run_state_e state;
   word_t      instr;
   word_t      top;
   word_t      next;
   word_t      alu_result;
   word_t      ram_q;
   word_t      dbus;
   addr_t      abus;
   addr_t      pc_next;
   logic       ram_we;
   addr_t      ram_addr;
   word_t      ram_d;

   stack_ctrl_if ctrl ();

   assign busy = (state != IDLE_A);

   // Load port wins over core writes
   assign ram_we   = prog_write || ctrl.ram_write;
   assign ram_addr = prog_write ? prog_addr : abus;
   assign ram_d    = prog_write ? prog_data : dbus;

   instr_decoder i_instr_decoder (
      .clk   (clk),
      .reset (reset),
      .run   (run),
      .instr (instr),
      .top   (top),
      .state (state),
      .ctrl  (ctrl)
   );

   operand_stack #(
      .STACK_DEPTH (STACK_DEPTH)
   ) i_operand_stack (
      .clk      (clk),
      .reset    (reset),
      .ctrl     (ctrl),
      .d        (dbus),
      .mem_data (ram_q),
      .top      (top),
      .next     (next)
   );

   stack_alu i_stack_alu (
      .a      (top),
      .b      (next),
      .func   (alu_func_e'(instr[FUNC_MSB:0])),
      .result (alu_result)
   );

   program_ram #(
      .RAM_WORDS (RAM_WORDS)
   ) i_program_ram (
      .clk        (clk),
      .write      (ram_we),
      .addr       (ram_addr),
      .d          (ram_d),
      .q          (ram_q),
      .fetch_addr (pc_next),
      .instr      (instr)
   );

   writeback_unit i_writeback_unit (
      .clk        (clk),
      .reset      (reset),
      .state      (state),
      .ctrl       (ctrl),
      .instr      (instr),
      .top        (top),
      .next       (next),
      .alu_result (alu_result),
      .ram_q      (ram_q),
      .in0        (in0),
      .in1        (in1),
      .in2        (in2),
      .in3        (in3),
      .dbus       (dbus),
      .abus       (abus),
      .pc_next    (pc_next),
      .out0       (out0),
      .out1       (out1),
      .out2       (out2),
      .out3       (out3)
   );

endmodule

// File: verification/stack_cpu_assertions.sv
// Stack CPU top-level checks
// Reset, busy and output port behaviour, bound into the core
`timescale 1ns/1ps

module stack_cpu_assertions (
   input logic                 clk,
   input logic                 reset,
   input logic                 run,
   input logic                 busy,
   input stack_cpu_pkg::word_t out0,
   input stack_cpu_pkg::word_t out1,
   input stack_cpu_pkg::word_t out2,
   input stack_cpu_pkg::word_t out3
);

   int failures = 0;   // Assertion failures so far

   // Core idles straight out of reset
   busy_low_after_reset: assert property (@(posedge clk) !reset |=> !busy)
      else
      begin
         failures++;
         $error("busy high in the cycle after reset");
      end

   // Ports only move at the end of an OUT in EXEC
   outs_hold_while_idle: assert property (@(posedge clk) disable iff (!reset)
      !$past(busy) |-> $stable({out0, out1, out2, out3}))
      else
      begin
         failures++;
         $error("output port changed while the core was idle");
      end

   // IDLE_A leaves only on run
   busy_rises_on_run: assert property (@(posedge clk) disable iff (!reset)
      $rose(busy) |-> $past(run))
      else
      begin
         failures++;
         $error("busy rose without run");
      end

endmodule

bind stack_cpu stack_cpu_assertions i_stack_cpu_assertions (
   .clk   (clk),
   .reset (reset),
   .run   (run),
   .busy  (busy),
   .out0  (out0),
   .out1  (out1),
   .out2  (out2),
   .out3  (out3)
);

// File: verification/stack_cpu_tb.sv
// Stack CPU testbench
// Loads each table program through the load port, runs it
// until busy falls and compares out0 with the hand-worked value
`timescale 1ns/1ps

module stack_cpu_tb;
   import stack_cpu_pkg::*;

   localparam int PROG_LEN   = 10;                    // Words per program
   localparam int ROW_BUDGET = PROG_LEN + 10 + 20;    // Load, reset, run

   typedef logic [0:PROG_LEN-1][WORD_WIDTH-1:0] prog_t;  // Word 0 leftmost

   logic  clk;
   logic  reset;
   logic  run;
   logic  prog_write;
   addr_t prog_addr;
   word_t prog_data;
   word_t in0;
   word_t in1;
   word_t in2;
   word_t in3;
   word_t out0;
   word_t out1;
   word_t out2;
   word_t out3;
   logic  busy;

   // Test table, one entry per row in each queue
   string names[$];
   prog_t progs[$];
   word_t in_a[$];
   word_t in_b[$];
   word_t expect_q[$];
   logic [3*WORD_WIDTH-1:0] expect_hi[$];   // out1, out2, out3

   int errors;
   int assert_fails;
   int cycles;
   int cycle_limit;

   stack_cpu i_stack_cpu (
      .clk        (clk),
      .reset      (reset),
      .run        (run),
      .prog_write (prog_write),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .in0        (in0),
      .in1        (in1),
      .in2        (in2),
      .in3        (in3),
      .out0       (out0),
      .out1       (out1),
      .out2       (out2),
      .out3       (out3),
      .busy       (busy)
   );

   always #5 clk = ~clk;                  // 10 ns period

   // Run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Program building
   //////////////////////////////////////////////////
   function automatic word_t encode(input opcode_e opc, input logic [11:0] arg);
      return {2'b00, opc, arg};           // Bits 17:16 unused
   endfunction

   // Missing words default to HALT
   function automatic prog_t pack_program(
      input word_t w0 = '0, input word_t w1 = '0, input word_t w2 = '0,
      input word_t w3 = '0, input word_t w4 = '0, input word_t w5 = '0,
      input word_t w6 = '0, input word_t w7 = '0, input word_t w8 = '0,
      input word_t w9 = '0);
      return {w0, w1, w2, w3, w4, w5, w6, w7, w8, w9};
   endfunction

   task automatic append_row(input string name, input word_t a, input word_t b,
                             input word_t exp, input prog_t p,
                             input logic [3*WORD_WIDTH-1:0] exp_hi = '0);
      names.push_back(name);
      progs.push_back(p);
      in_a.push_back(a);
      in_b.push_back(b);
      expect_q.push_back(exp);
      expect_hi.push_back(exp_hi);
   endtask

   // IN 0, IN 1, OP f, OUT 0 gives in0 op in1
   task automatic alu_row(input string name, input alu_func_e f, input word_t a,
                          input word_t b, input word_t exp);
      append_row(name, a, b, exp, pack_program(encode(OPC_IN, 12'h000),
         encode(OPC_IN, 12'h001), encode(OPC_OP, 12'(f)), encode(OPC_OUT, 12'h000)));
   endtask

   // Taken lands on 0x222 at address 5, fall through gives 0x111
   function automatic prog_t branch_program(input opcode_e opc);
      return pack_program(encode(OPC_IN, 12'h000), encode(opc, 12'h005),
         encode(OPC_PUSHI, 12'h111), encode(OPC_OUT, 12'h000), encode(OPC_HALT, 12'h000),
         encode(OPC_PUSHI, 12'h222), encode(OPC_OUT, 12'h000));
   endfunction

   task automatic build_table();
      // Immediate 0x800 sign extends to 0x3F800, ports 1 to 3 get 0x11, 0x22, 0x33
      append_row("pushi_out", 18'h0, 18'h0, 18'h3F800, pack_program(
         encode(OPC_PUSHI, 12'h800), encode(OPC_OUT, 12'h000),
         encode(OPC_PUSHI, 12'h011), encode(OPC_OUT, 12'h001),
         encode(OPC_PUSHI, 12'h022), encode(OPC_OUT, 12'h002),
         encode(OPC_PUSHI, 12'h033), encode(OPC_OUT, 12'h003)),
         {18'h00011, 18'h00022, 18'h00033});

      alu_row("add",      ALU_ADD,  18'h00123, 18'h00456, 18'h00579);
      alu_row("sub",      ALU_SUB,  18'h00100, 18'h00250, 18'h3FEB0);
      alu_row("mul",      ALU_MUL,  18'h00200, 18'h3FE80, 18'h3FD00);   // 2.0 x -1.5
      alu_row("mul_frac", ALU_MUL,  18'h00180, 18'h00180, 18'h00240);   // 1.5 x 1.5
      alu_row("shl",      ALU_SHL,  18'h00003, 18'h00004, 18'h00030);
      alu_row("shr",      ALU_SHR,  18'h2F000, 18'h00008, 18'h002F0);
      alu_row("band",     ALU_BAND, 18'h3C3C3, 18'h0FF0F, 18'h0C303);
      alu_row("bor",      ALU_BOR,  18'h30000, 18'h0000F, 18'h3000F);
      alu_row("bxor",     ALU_BXOR, 18'h3FFFF, 18'h15555, 18'h2AAAA);
      alu_row("ge_neg",   ALU_GE,   18'h3FFFB, 18'h00003, 18'h00000);   // -5 >= 3
      alu_row("lt_neg",   ALU_LT,   18'h3FFFB, 18'h00003, 18'h00001);
      alu_row("gt_neg",   ALU_GT,   18'h00003, 18'h3FFFB, 18'h00001);
      alu_row("le_eq",    ALU_LE,   18'h3FFFE, 18'h3FFFE, 18'h00001);
      alu_row("eq",       ALU_EQ,   18'h12345, 18'h12345, 18'h00001);
      alu_row("land",     ALU_AND,  18'h00005, 18'h00000, 18'h00000);
      alu_row("lor",      ALU_OR,   18'h00000, 18'h00007, 18'h00001);
      alu_row("lnot",     ALU_NOT,  18'h00009, 18'h00000, 18'h00001);   // Acts on in1
      alu_row("neg",      ALU_NEG,  18'h00000, 18'h00005, 18'h3FFFB);
      alu_row("bnot",     ALU_BNOT, 18'h00000, 18'h0F0F0, 18'h30F0F);

      //////////////////////////////////////////////////
      // Memory, read back through the through path
      //////////////////////////////////////////////////
      append_row("pop_push", 18'h1D00D, 18'h0, 18'h1D00D, pack_program(
         encode(OPC_IN, 12'h000), encode(OPC_POP, 12'h200),
         encode(OPC_PUSH, 12'h200), encode(OPC_OUT, 12'h000)));
      append_row("ld_st", 18'h2BEEF, 18'h0, 18'h2BEEF, pack_program(
         encode(OPC_PUSHI, 12'h300), encode(OPC_IN, 12'h000), encode(OPC_ST, 12'h000),
         encode(OPC_PUSHI, 12'h300), encode(OPC_LD, 12'h000), encode(OPC_OUT, 12'h000)));
      // Loaded value sinks under a following push
      append_row("ld_sink", 18'h2BEEF, 18'h0, 18'h2BEF0, pack_program(
         encode(OPC_PUSHI, 12'h301), encode(OPC_IN, 12'h000), encode(OPC_ST, 12'h000),
         encode(OPC_PUSHI, 12'h301), encode(OPC_LD, 12'h000),
         encode(OPC_PUSHI, 12'h001), encode(OPC_OP, 12'(ALU_ADD)),
         encode(OPC_OUT, 12'h000)));
      // ST of a through value leaves the word beneath intact
      append_row("st_thru", 18'h1ABCD, 18'h0, 18'h00077, pack_program(
         encode(OPC_PUSHI, 12'h077), encode(OPC_PUSHI, 12'h310), encode(OPC_IN, 12'h000),
         encode(OPC_POP, 12'h320), encode(OPC_PUSH, 12'h320), encode(OPC_ST, 12'h000),
         encode(OPC_OUT, 12'h000)));

      // Control flow
      append_row("jz_taken",  18'h00000, 18'h0, 18'h00222, branch_program(OPC_JZ));
      append_row("jz_skip",   18'h00007, 18'h0, 18'h00111, branch_program(OPC_JZ));
      append_row("jnz_taken", 18'h20000, 18'h0, 18'h00222, branch_program(OPC_JNZ));
      append_row("jnz_skip",  18'h00000, 18'h0, 18'h00111, branch_program(OPC_JNZ));
      append_row("jmp", 18'h0, 18'h0, 18'h000AA, pack_program(
         encode(OPC_PUSHI, 12'h0AA), encode(OPC_OUT, 12'h000), encode(OPC_JMP, 12'h005),
         encode(OPC_PUSHI, 12'h0BB), encode(OPC_OUT, 12'h000)));
      // Return address 1 + 3 = 4, subroutine at 7 leaves 0xEE
      append_row("call", 18'h0, 18'h0, 18'h000EE, pack_program(
         encode(OPC_PPPC, 12'h000), encode(OPC_PUSHI, 12'h003),
         encode(OPC_OP, 12'(ALU_ADD)), encode(OPC_JMP, 12'h007),
         encode(OPC_OUT, 12'h000), encode(OPC_HALT, 12'h000), encode(OPC_HALT, 12'h000),
         encode(OPC_PUSHI, 12'h0EE), encode(OPC_OP, 12'(ALU_BA)),
         encode(OPC_PPPC, 12'h001)));

      //////////////////////////////////////////////////
      // Stack shuffles
      //////////////////////////////////////////////////
      append_row("dup", 18'h00100, 18'h00030, 18'h001D0, pack_program(   // 2x - y
         encode(OPC_IN, 12'h000), encode(OPC_OP, 12'(ALU_A)), encode(OPC_IN, 12'h001),
         encode(OPC_OP, 12'(ALU_SUB)), encode(OPC_OP, 12'(ALU_ADD)),
         encode(OPC_OUT, 12'h000)));
      append_row("over", 18'h00010, 18'h00035, 18'h00025, pack_program(  // y - x
         encode(OPC_IN, 12'h000), encode(OPC_IN, 12'h001), encode(OPC_OP, 12'(ALU_BA)),
         encode(OPC_OP, 12'(ALU_SUB)), encode(OPC_OUT, 12'h000)));
      append_row("drop", 18'h00010, 18'h00099, 18'h00040, pack_program(  // z - x
         encode(OPC_PUSHI, 12'h050), encode(OPC_IN, 12'h000), encode(OPC_IN, 12'h001),
         encode(OPC_OP, 12'(ALU_B)), encode(OPC_OP, 12'(ALU_SUB)),
         encode(OPC_OUT, 12'h000)));
      append_row("dropnext", 18'h00010, 18'h00008, 18'h00048, pack_program(  // z - y
         encode(OPC_PUSHI, 12'h050), encode(OPC_IN, 12'h000), encode(OPC_IN, 12'h001),
         encode(OPC_OP, 12'(ALU_AA)), encode(OPC_OP, 12'(ALU_SUB)),
         encode(OPC_OUT, 12'h000)));
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   task automatic load_program(input prog_t p);
      for (int i = 0; i < PROG_LEN; i++)
      begin
         @(posedge clk);
         prog_write <= 1'b1;
         prog_addr  <= addr_t'(i);
         prog_data  <= p[i];
      end
      @(posedge clk);
      prog_write <= 1'b0;
   endtask

   task automatic pulse_reset(input int n);
      @(posedge clk);
      reset <= 1'b0;
      repeat (n) @(posedge clk);
      reset <= 1'b1;
   endtask

   // busy is read before the edge updates it
   task automatic run_program();
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      while (!busy)
         @(posedge clk);
      run <= 1'b0;                        // One run per row
      while (busy)
         @(posedge clk);
   endtask

   task automatic check_reset_state();
      assert (busy == 1'b0)
      else
      begin
         errors++;
         $display("MISMATCH reset busy: expected 0, actual %0b", busy);
      end
      assert ({out0, out1, out2, out3} == '0)
      else
      begin
         errors++;
         $display("MISMATCH reset outputs: expected 0, actual %05h %05h %05h %05h",
                  out0, out1, out2, out3);
      end
   endtask

   task automatic run_row(input int r);
      load_program(progs[r]);
      in0 <= in_a[r];
      in1 <= in_b[r];
      pulse_reset(2);                     // PC, stack and ports back to zero
      run_program();
      assert (out0 == expect_q[r])
      else
      begin
         errors++;
         $display("MISMATCH %s: expected %05h, actual %05h", names[r], expect_q[r], out0);
      end
      assert ({out1, out2, out3} == expect_hi[r])
      else
      begin
         errors++;
         $display("MISMATCH %s out1-out3: expected %014h, actual %014h",
                  names[r], expect_hi[r], {out1, out2, out3});
      end
   endtask

   initial
   begin
      clk          = 1'b0;
      reset        = 1'b0;                // Held from time zero
      run          = 1'b0;
      prog_write   = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      in0          = '0;
      in1          = '0;
      in2          = '0;
      in3          = '0;
      errors       = 0;
      assert_fails = 0;
      cycles       = 0;
      build_table();
      cycle_limit = names.size() * ROW_BUDGET;

      repeat (10) @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      check_reset_state();

      for (int r = 0; r < names.size(); r++)
         run_row(r);

      assert_fails = i_stack_cpu.i_stack_cpu_assertions.failures;
      $display("Errors: %0d check, %0d assertion, over %0d rows",
               errors, assert_fails, names.size());
      if (errors == 0 && assert_fails == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: stack_cpu.f
design/stack_cpu_pkg.sv
design/stack_ctrl_if.sv
design/instr_decoder.sv
design/operand_stack.sv
design/stack_alu.sv
design/program_ram.sv
design/writeback_unit.sv
design/stack_cpu.sv
verification/stack_cpu_assertions.sv
verification/stack_cpu_tb.sv

// File: Makefile
# Verilator build and run for the stack CPU core
TOP := stack_cpu_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f stack_cpu.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f stack_cpu.f

clean:
	rm -rf obj_dir sim.log
